// File: tb.f
logic/pmod_pkg.sv
logic/codec_tdm.sv
logic/sample_cal.sv
logic/uart_tx.sv
logic/sample_reporter.sv
logic/pmod_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: Makefile
# Verilator build and run for the eurorack sample path testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns -j 0
TOP       = tb_top
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_top.sv
`timescale 1ns/1ns
// Testbench top for the eurorack sample path
// Clock, reset, random ADC frames on the serial codec line and the end of run
module tb_top;

    localparam int bick_div       = 1;
    localparam int clks_per_bit   = 8;
    localparam int drive_delay    = 1;
    localparam int num_reports    = 16;
    localparam int timeout_cycles = 60000;

    logic CLK   = 1'b0;
    logic rst   = 1'b1;
    logic sdout = 1'b0;
    logic pdn;
    logic bick;
    logic lrck;
    logic sdin;
    logic tx;
    logic led_sample;
    logic led_frame;

    // ADC model state
    logic [31:0] rng_state = 32'h285b;
    logic [15:0] frame_words [4];
    logic [6:0]  bit_pos   = 7'd0;
    logic        prev_bick = 1'b0;
    logic        started   = 1'b0;

    int errors;
    int dac_checked;
    int reports;

    always #4 CLK = ~CLK;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Four new ADC words, with full-scale values mixed in
    task automatic new_frame();
        for (int s = 0; s < 4; s++) begin
            rng_state = xorshift(rng_state);
            case (rng_state[2:0])
                3'd0:    frame_words[s] = 16'h8000;
                3'd1:    frame_words[s] = 16'h7fff;
                default: frame_words[s] = rng_state[31:16];
            endcase
        end
    endtask

    // Slot data is 16 bits MSB first, then zeros
    function automatic logic adc_bit(input logic [6:0] pos);
        if (pos[4]) begin
            return 1'b0;
        end
        return frame_words[pos[6:5]][4'd15 - pos[3:0]];
    endfunction

    // Serial ADC: next bit goes out after each falling bick
    always @(posedge CLK) begin
        #drive_delay;
        if (!bick) begin
            if (prev_bick) begin
                bit_pos = bit_pos + 7'd1;
            end
            if (bit_pos == 7'd0 && (prev_bick || !started)) begin
                started = 1'b1;
                new_frame();
            end
            sdout = adc_bit(bit_pos);
        end
        prev_bick = bick;
    end

    pmod_top #(
        .bick_div(bick_div),
        .clks_per_bit(clks_per_bit)
    ) i_dut (
        .CLK(CLK), .rst(rst), .sdout(sdout),
        .pdn(pdn), .bick(bick), .lrck(lrck), .sdin(sdin),
        .tx(tx), .led_sample(led_sample), .led_frame(led_frame)
    );

    tb_checker #(.clks_per_bit(clks_per_bit)) u_checker (
        .CLK(CLK), .rst(rst), .pdn(pdn), .bick(bick), .lrck(lrck),
        .sdout(sdout), .sdin(sdin), .tx(tx),
        .led_sample(led_sample), .led_frame(led_frame),
        .errors(errors), .dac_checked(dac_checked), .reports(reports)
    );

    initial begin
        int   cycles;
        logic timed_out;
        repeat (16) @(posedge CLK);
        #drive_delay;
        rst = 1'b0;
        cycles = 0;
        while (reports < num_reports && cycles < timeout_cycles) begin
            @(posedge CLK);
            cycles++;
        end
        timed_out = (reports < num_reports);
        if (timed_out) begin
            $display("Timeout: only %0d of %0d UART reports arrived within %0d cycles",
                     reports, num_reports, timeout_cycles);
        end
        if (dac_checked == 0) begin
            $display("No DAC word was checked during the run");
        end
        $display("Errors: %0d, DAC words checked: %0d, UART reports checked: %0d",
                 errors, dac_checked, reports);
        if (!timed_out && errors == 0 && dac_checked > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/tb_checker.sv
`timescale 1ns/1ns
// Testbench checker
// Rebuilds ADC and DAC words from the TDM lines and UART bytes from tx,
// and compares them with the calibration model
module tb_checker #(
    parameter int clks_per_bit = 8
) (
    input  logic CLK,
    input  logic rst,
    input  logic pdn,
    input  logic bick,
    input  logic lrck,
    input  logic sdout,
    input  logic sdin,
    input  logic tx,
    input  logic led_sample,
    input  logic led_frame,
    output int   errors,
    output int   dac_checked,
    output int   reports
);
    import pmod_pkg::*;

    logic        prev_bick;
    logic        prev_tx;
    logic        prev_led_s;
    logic        prev_led_f;
    logic [6:0]  pos;
    int          frame;
    int          cyc;
    logic [15:0] adc_sr;
    logic [15:0] dac_sr;
    logic [15:0] adc_q [$];
    int          strobe_cyc [$];
    logic        rx_active;
    int          start_cyc;
    logic [7:0]  rx_byte;
    logic [7:0]  msb_byte;
    int          byte_idx;
    int          chan_exp;
    int          digit_cyc;
    int          led_s_cnt;
    int          led_f_cnt;

    task automatic mismatch(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic problem(input string msg);
        $display("%s (at %0t)", msg, $time);
        errors++;
    endtask

    // Offset, Q4.12 gain with floor shift, then clamp to 16 bits
    function automatic sample_t cal_apply(input int idx, input sample_t s);
        longint d;
        longint p;
        d = longint'(s) - longint'(cal_offset[idx]);
        p = (d * longint'(cal_gain[idx])) >>> cal_shift;
        if (p > 32767) begin
            return 16'sh7fff;
        end
        if (p < -32768) begin
            return 16'sh8000;
        end
        return sample_t'(p[15:0]);
    endfunction

    // One bit on each rising bick, slot words complete at bit 15
    task automatic take_bit();
        int      slot;
        int      base;
        sample_t exp_dac;
        pos = pos + 7'd1;
        if (pos == 7'd0) begin
            frame++;
        end
        if (lrck !== (pos[6:5] == 2'd0)) begin
            mismatch($sformatf("lrck is %b at bit %0d of frame %0d", lrck, pos, frame));
        end
        if (pos[4]) begin
            if (sdin !== 1'b0) begin
                mismatch($sformatf("sdin is high in padding bit %0d", pos));
            end
        end else begin
            adc_sr = {adc_sr[14:0], sdout};
            dac_sr = {dac_sr[14:0], sdin};
            if (pos[3:0] == 4'd15) begin
                slot = int'(pos[6:5]);
                adc_q.push_back(adc_sr);
                // DAC carries the result of the ADC frame two frames back
                if (frame >= 2) begin
                    base = (frame - 2) * num_ch + slot;
                    exp_dac = cal_apply(slot + num_ch, cal_apply(slot, sample_t'(~adc_q[base])));
                    if (dac_sr !== exp_dac) begin
                        mismatch($sformatf("DAC slot %0d frame %0d is %h, expected %h",
                                           slot, frame, dac_sr, exp_dac));
                    end
                    dac_checked++;
                end
            end
        end
    endtask

    task automatic byte_started();
        int exp_s;
        int exp_f;
        if (byte_idx == 2) begin
            digit_cyc = cyc;
        end
        // led_sample flips before the MSB, led_frame with the LSB
        exp_s = (byte_idx >= 3) ? reports + 1 : reports;
        exp_f = (byte_idx == 4) ? reports + 1 : reports;
        if (led_s_cnt != exp_s || led_f_cnt != exp_f) begin
            mismatch($sformatf("LED toggles %0d/%0d at byte %0d, expected %0d/%0d",
                               led_s_cnt, led_f_cnt, byte_idx, exp_s, exp_f));
        end
    endtask

    task automatic take_byte(input logic [7:0] b);
        sample_word_t got;
        sample_word_t want;
        int           k;
        case (byte_idx)
            0: if (b !== "C") mismatch($sformatf("report byte 0 is %h, expected C", b));
            1: if (b !== "H") mismatch($sformatf("report byte 1 is %h, expected H", b));
            2: if (b !== 8'h30 + 8'(chan_exp)) begin
                mismatch($sformatf("channel digit is %h, expected %0d", b, chan_exp));
            end
            3: msb_byte = b;
            default: begin
                // First strobe whose cycle allows the latch after the digit start
                k = -1;
                foreach (strobe_cyc[i]) begin
                    if (k < 0 && strobe_cyc[i] >= digit_cyc - 1) begin
                        k = i;
                    end
                end
                got.bytes.msb = msb_byte;
                got.bytes.lsb = b;
                if (k < 0) begin
                    problem("A report was sent with no sample strobe after its digit byte");
                end else begin
                    want.value = (k == 0) ? 16'sd0 :
                        cal_apply(chan_exp, sample_t'(~adc_q[(k - 1) * num_ch + chan_exp]));
                    if (got.value !== want.value) begin
                        mismatch($sformatf("report channel %0d sample %h, expected %h",
                                           chan_exp, got.value, want.value));
                    end
                end
                reports++;
                chan_exp = (chan_exp + 1) % num_ch;
            end
        endcase
        byte_idx = (byte_idx + 1) % 5;
    endtask

    // UART receiver sampling tx at mid-bit
    task automatic uart_step();
        int off;
        if (!rx_active) begin
            if (!tx && prev_tx) begin
                rx_active = 1'b1;
                start_cyc = cyc;
                byte_started();
            end
        end else begin
            off = cyc - start_cyc;
            if (off == clks_per_bit / 2) begin
                if (tx !== 1'b0) begin
                    problem("The UART start bit did not stay low");
                    rx_active = 1'b0;
                end
            end else if (off > clks_per_bit && off < 9 * clks_per_bit &&
                         off % clks_per_bit == clks_per_bit / 2) begin
                rx_byte = {tx, rx_byte[7:1]};
            end else if (off == 9 * clks_per_bit + clks_per_bit / 2) begin
                rx_active = 1'b0;
                if (tx !== 1'b1) begin
                    problem("The UART stop bit was low");
                end else begin
                    take_byte(rx_byte);
                end
            end
        end
    endtask

    always @(negedge CLK) begin
        if (rst) begin
            if (pdn !== 1'b0) begin
                mismatch("pdn is not low during reset");
            end
            prev_bick    = 1'b0;
            prev_tx      = 1'b1;
            prev_led_s   = 1'b0;
            prev_led_f   = 1'b0;
            cyc          = 0;
            pos          = 7'd127;
            frame        = -1;
            rx_active    = 1'b0;
            byte_idx     = 0;
            chan_exp     = 0;
        end else begin
            cyc++;
            // The DUT has seen one clock edge with rst low by now
            if (cyc == 2) begin
                if (tx !== 1'b1 || led_sample !== 1'b0 || led_frame !== 1'b0 || pdn !== 1'b1) begin
                    mismatch($sformatf("after reset tx=%b led_sample=%b led_frame=%b pdn=%b",
                                       tx, led_sample, led_frame, pdn));
                end
            end
            if (led_sample != prev_led_s) begin
                led_s_cnt++;
            end
            if (led_frame != prev_led_f) begin
                led_f_cnt++;
            end
            if (bick && !prev_bick) begin
                take_bit();
            end
            // Strobe cycle is the bick fall after data bit 111
            if (!bick && prev_bick && pos == 7'd111) begin
                strobe_cyc.push_back(cyc);
            end
            uart_step();
            prev_bick  = bick;
            prev_tx    = tx;
            prev_led_s = led_sample;
            prev_led_f = led_frame;
        end
    end

endmodule

// File: logic/pmod_top.sv
`timescale 1ns/1ns
// Eurorack sample path top level
// Codec port, input and output calibration, mirror core and UART reporter
module pmod_top #(
    parameter int bick_div     = 2,
    parameter int clks_per_bit = 104
) (
    input  logic CLK,
    input  logic rst,
    input  logic sdout,
    output logic pdn,
    output logic bick,
    output logic lrck,
    output logic sdin,
    output logic tx,
    output logic led_sample,
    output logic led_frame
);
    import pmod_pkg::*;

    logic       sample_strobe;
    sample_t    adc0, adc1, adc2, adc3;
    sample_t    dac0, dac1, dac2, dac3;
    sample_t    cal_in0, cal_in1, cal_in2, cal_in3;
    sample_t    core_out0, core_out1, core_out2, core_out3;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;

    codec_tdm #(.bick_div(bick_div)) u_codec (
        .CLK(CLK), .rst(rst), .sdout(sdout),
        .dac0(dac0), .dac1(dac1), .dac2(dac2), .dac3(dac3),
        .pdn(pdn), .bick(bick), .lrck(lrck), .sdin(sdin),
        .sample_strobe(sample_strobe),
        .adc0(adc0), .adc1(adc1), .adc2(adc2), .adc3(adc3)
    );

    // The analog front end inverts the ADC words
    sample_cal u_cal (
        .CLK(CLK), .rst(rst), .sample_strobe(sample_strobe),
        .in0(~adc0), .in1(~adc1), .in2(~adc2), .in3(~adc3),
        .in4(core_out0), .in5(core_out1), .in6(core_out2), .in7(core_out3),
        .out0(cal_in0), .out1(cal_in1), .out2(cal_in2), .out3(cal_in3),
        .out4(dac0), .out5(dac1), .out6(dac2), .out7(dac3)
    );

    // Mirror core
    assign core_out0 = cal_in0;
    assign core_out1 = cal_in1;
    assign core_out2 = cal_in2;
    assign core_out3 = cal_in3;

    sample_reporter u_reporter (
        .CLK(CLK), .rst(rst), .sample_strobe(sample_strobe), .busy(tx_busy),
        .cal_in0(cal_in0), .cal_in1(cal_in1), .cal_in2(cal_in2), .cal_in3(cal_in3),
        .tx_start(tx_start), .tx_data(tx_data),
        .led_sample(led_sample), .led_frame(led_frame)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) u_uart (
        .CLK(CLK), .rst(rst), .tx_start(tx_start), .tx_data(tx_data),
        .tx(tx), .busy(tx_busy)
    );

endmodule

// File: logic/sample_reporter.sv
`timescale 1ns/1ns
// Sample reporter
// Sends "CH", the channel digit and one calibrated sample per channel
// over the UART, rotating through the input channels
module sample_reporter (
    input  logic              CLK,
    input  logic              rst,
    input  logic              sample_strobe,
    input  logic              busy,
    input  pmod_pkg::sample_t cal_in0,
    input  pmod_pkg::sample_t cal_in1,
    input  pmod_pkg::sample_t cal_in2,
    input  pmod_pkg::sample_t cal_in3,
    output logic              tx_start,
    output logic [7:0]        tx_data,
    output logic              led_sample,
    output logic              led_frame
);
    import pmod_pkg::*;

    typedef enum logic [2:0] {
        st_c,
        st_h,
        st_digit,
        st_msb,
        st_lsb
    } step_t;

    step_t        step;
    logic [1:0]   chan;
    logic         latched;
    sample_word_t word;
    sample_t      chan_sample;
    logic         can_send;

    always_comb begin
        case (chan)
            2'd0:    chan_sample = cal_in0;
            2'd1:    chan_sample = cal_in1;
            2'd2:    chan_sample = cal_in2;
            default: chan_sample = cal_in3;
        endcase
    end

    // Skip the cycle right after a start, before busy shows up
    assign can_send = !busy && !tx_start;

    always_ff @(posedge CLK) begin
        if (rst) begin
            step       <= st_c;
            chan       <= '0;
            latched    <= 1'b0;
            tx_start   <= 1'b0;
            led_sample <= 1'b0;
            led_frame  <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            // Latch step: take the first sample after the digit went out
            if (step == st_msb && !latched && sample_strobe) begin
                word.value <= chan_sample;
                latched    <= 1'b1;
                led_sample <= ~led_sample;
            end
            if (can_send) begin
                case (step)
                    st_c: begin
                        tx_data  <= "C";
                        tx_start <= 1'b1;
                        step     <= st_h;
                    end
                    st_h: begin
                        tx_data  <= "H";
                        tx_start <= 1'b1;
                        step     <= st_digit;
                    end
                    st_digit: begin
                        tx_data  <= "0" + {6'd0, chan};
                        tx_start <= 1'b1;
                        step     <= st_msb;
                    end
                    st_msb: begin
                        if (latched) begin
                            tx_data  <= word.bytes.msb;
                            tx_start <= 1'b1;
                            step     <= st_lsb;
                        end
                    end
                    default: begin
                        tx_data   <= word.bytes.lsb;
                        tx_start  <= 1'b1;
                        step      <= st_c;
                        latched   <= 1'b0;
                        led_frame <= ~led_frame;
                        chan      <= (chan == 2'(num_ch - 1)) ? 2'd0 : chan + 2'd1;
                    end
                endcase
            end
        end
    end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ns
// UART transmitter, 8N1
// Start bit, eight data bits LSB first, stop bit; busy covers the frame
module uart_tx #(
    parameter int clks_per_bit = 104
) (
    input  logic       CLK,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx,
    output logic       busy
);
    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

    logic [cnt_w-1:0] clk_cnt;
    logic [3:0]       bit_idx;
    logic [8:0]       frame;
    logic             bit_done;

    assign bit_done = (clk_cnt == cnt_w'(clks_per_bit - 1));

    always_ff @(posedge CLK) begin
        if (rst) begin
            tx      <= 1'b1;
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (tx_start) begin
                tx      <= 1'b0;
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (bit_done) begin
            clk_cnt <= '0;
            // Index 9 is the stop bit
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;
            end else begin
                tx      <= frame[0];
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Remaining data bits plus the stop bit
    always_ff @(posedge CLK) begin
        if (!busy && tx_start) begin
            frame <= {1'b1, tx_data};
        end else if (busy && bit_done) begin
            frame <= {1'b1, frame[8:1]};
        end
    end

endmodule

// File: logic/sample_cal.sv
`timescale 1ns/1ns
// Channel calibration
// Steps one offset, gain and saturate datapath through all eight
// channels after each sample strobe
module sample_cal (
    input  logic              CLK,
    input  logic              rst,
    input  logic              sample_strobe,
    input  pmod_pkg::sample_t in0,
    input  pmod_pkg::sample_t in1,
    input  pmod_pkg::sample_t in2,
    input  pmod_pkg::sample_t in3,
    input  pmod_pkg::sample_t in4,
    input  pmod_pkg::sample_t in5,
    input  pmod_pkg::sample_t in6,
    input  pmod_pkg::sample_t in7,
    output pmod_pkg::sample_t out0,
    output pmod_pkg::sample_t out1,
    output pmod_pkg::sample_t out2,
    output pmod_pkg::sample_t out3,
    output pmod_pkg::sample_t out4,
    output pmod_pkg::sample_t out5,
    output pmod_pkg::sample_t out6,
    output pmod_pkg::sample_t out7
);
    import pmod_pkg::*;

    localparam int num_cal = 2 * num_ch;

    sample_t                      snap  [num_cal];
    sample_t                      out_r [num_cal];
    logic [$clog2(num_cal)-1:0]   ch;
    logic                         active;
    logic signed [16:0]           diff;
    logic signed [33:0]           prod;
    logic signed [33:0]           scaled;
    sample_t                      result;

    // Shared datapath for the channel being processed
    assign diff   = snap[ch] - cal_offset[ch];
    assign prod   = diff * $signed({1'b0, cal_gain[ch]});
    assign scaled = prod >>> cal_shift;

    always_comb begin
        if (scaled > 34'sd32767) begin
            result = 16'sh7fff;
        end else if (scaled < -34'sd32768) begin
            result = 16'sh8000;
        end else begin
            result = scaled[15:0];
        end
    end

    always_ff @(posedge CLK) begin
        if (sample_strobe) begin
            snap[0] <= in0;
            snap[1] <= in1;
            snap[2] <= in2;
            snap[3] <= in3;
            snap[4] <= in4;
            snap[5] <= in5;
            snap[6] <= in6;
            snap[7] <= in7;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            active <= 1'b0;
            ch     <= '0;
            for (int i = 0; i < num_cal; i++) begin
                out_r[i] <= '0;
            end
        end else if (sample_strobe) begin
            active <= 1'b1;
            ch     <= '0;
        end else if (active) begin
            out_r[ch] <= result;
            if (ch == $clog2(num_cal)'(num_cal - 1)) begin
                active <= 1'b0;
            end
            ch <= ch + 1'b1;
        end
    end

    assign out0 = out_r[0];
    assign out1 = out_r[1];
    assign out2 = out_r[2];
    assign out3 = out_r[3];
    assign out4 = out_r[4];
    assign out5 = out_r[5];
    assign out6 = out_r[6];
    assign out7 = out_r[7];

endmodule

// File: logic/codec_tdm.sv
`timescale 1ns/1ns
// TDM codec port
// Makes bit and frame clocks for four 32-bit slots and moves 16-bit
// ADC and DAC words between the serial lines and parallel ports
module codec_tdm #(
    parameter int bick_div = 2
) (
    input  logic              CLK,
    input  logic              rst,
    input  logic              sdout,
    input  pmod_pkg::sample_t dac0,
    input  pmod_pkg::sample_t dac1,
    input  pmod_pkg::sample_t dac2,
    input  pmod_pkg::sample_t dac3,
    output logic              pdn,
    output logic              bick,
    output logic              lrck,
    output logic              sdin,
    output logic              sample_strobe,
    output pmod_pkg::sample_t adc0,
    output pmod_pkg::sample_t adc1,
    output pmod_pkg::sample_t adc2,
    output pmod_pkg::sample_t adc3
);
    localparam int div_w = (bick_div > 1) ? $clog2(bick_div) : 1;
    // Last data bit of slot 3, all ADC words are complete after it
    localparam logic [6:0] last_data_bit = 7'd111;

    logic [div_w-1:0] div_cnt;
    logic [6:0]       bit_cnt;
    logic [6:0]       next_bit;
    logic             tick;
    logic             bick_rise;
    logic             bick_fall;
    logic [63:0]      rx_shift;
    logic [63:0]      tx_shift;

    assign tick      = (div_cnt == div_w'(bick_div - 1));
    assign bick_rise = tick & ~bick;
    assign bick_fall = tick & bick;
    assign next_bit  = bit_cnt + 7'd1;

    always_ff @(posedge CLK) begin
        if (rst) begin
            pdn           <= 1'b0;
            div_cnt       <= '0;
            bick          <= 1'b0;
            bit_cnt       <= '0;
            lrck          <= 1'b1;
            sdin          <= 1'b0;
            tx_shift      <= '0;
            sample_strobe <= 1'b0;
        end else begin
            pdn           <= 1'b1;
            sample_strobe <= 1'b0;
            div_cnt       <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                bick <= ~bick;
            end
            // Everything on the serial side moves on the falling bick
            if (bick_fall) begin
                bit_cnt <= next_bit;
                lrck    <= (next_bit[6:5] == 2'd0);
                if (next_bit == 7'd0) begin
                    // New frame, take the DAC words
                    tx_shift <= {dac0[14:0], dac1, dac2, dac3, 1'b0};
                    sdin     <= dac0[15];
                end else if (!next_bit[4]) begin
                    tx_shift <= {tx_shift[62:0], 1'b0};
                    sdin     <= tx_shift[63];
                end else begin
                    sdin <= 1'b0;
                end
                if (bit_cnt == last_data_bit) begin
                    sample_strobe <= 1'b1;
                end
            end
        end
    end

    // Receive side, data bits only
    always_ff @(posedge CLK) begin
        if (bick_rise && !bit_cnt[4]) begin
            rx_shift <= {rx_shift[62:0], sdout};
        end
        if (bick_fall && bit_cnt == last_data_bit) begin
            adc0 <= rx_shift[63:48];
            adc1 <= rx_shift[47:32];
            adc2 <= rx_shift[31:16];
            adc3 <= rx_shift[15:0];
        end
    end

endmodule

// File: logic/pmod_pkg.sv
// Shared types and constants for the eurorack sample path
// Sample word views, channel count and the fixed calibration table
package pmod_pkg;

    localparam int num_ch = 4;

    typedef logic signed [15:0] sample_t;

    typedef struct packed {
        logic [7:0] msb;
        logic [7:0] lsb;
    } sample_bytes_t;

    // One sample word, seen as a number or as two UART bytes
    typedef union packed {
        sample_t       value;
        sample_bytes_t bytes;
    } sample_word_t;

    // Entries 0-3 correct the inputs, 4-7 the outputs
    localparam sample_t cal_offset [8] = '{
        16'sd212, -16'sd148, 16'sd64, -16'sd305,
        -16'sd96, 16'sd141, 16'sd0, 16'sd230
    };

    // Q4.12 gains, 4096 is unity
    localparam logic [15:0] cal_gain [8] = '{
        16'd4506, 16'd4096, 16'd3891, 16'd4710,
        16'd4300, 16'd3686, 16'd4915, 16'd4096
    };

    localparam int cal_shift = 12;

endpackage
